//--- common/pipe_phy_consts.svh
// Lane count, counter widths, detect timing and RxValid stability constants
`ifndef PIPE_PHY_CONSTS_SVH
`define PIPE_PHY_CONSTS_SVH

// ========================================
// Lane configuration
// ========================================

// Number of PIPE lanes handled by the wrapper
`define PHY_LANES 4

// Receive status field per lane, PIPE RxStatus encoding
`define RX_STATUS_W 3

// ========================================
// Receiver-detect timing
// ========================================

// Detect enable on before charge timing
// 255 clocks, about 1 us at 250 MHz
`define DET_EN_CYCLES 255

// Charge-timing pulse length in clocks
`define DET_CT_CYCLES 4

// Detect timing counter, must hold DET_EN_CYCLES
`define DET_CNT_W 8

// ========================================
// RxValid qualification
// ========================================

// Clean receive cycles needed before RxValid is passed on
`define RX_STABLE_CYCLES 100

// Stability counter, saturates at RX_STABLE_CYCLES
`define RX_CNT_W 10

`endif

//--- common/pipe_phy_pkg.sv
// Shared types: receiver-detect FSM states and PIPE power states
package pipe_phy_pkg;

   // ========================================
   // Receiver-detect sequencer states
   // ========================================

   // IDLE waits for the request edge
   // EN holds detect enable for the settle time
   // CT drives the charge-timing pulse
   // WAIT_DONE waits until every lane has reported done
   typedef enum logic [1:0] {
      DET_IDLE      = 2'd0,
      DET_EN        = 2'd1,
      DET_CT        = 2'd2,
      DET_WAIT_DONE = 2'd3
   } det_state_e;

   // ========================================
   // PIPE PowerDown encoding
   // ========================================

   // P0 normal operation
   // P0S low recovery time standby
   // P1 deep standby, receiver detect only here
   // P2 lowest power, PCLK may stop
   typedef enum logic [1:0] {
      P0  = 2'd0,
      P0S = 2'd1,
      P1  = 2'd2,
      P2  = 2'd3
   } power_state_e;

endpackage

//--- rx_detect/rx_detect_seq.sv
// Receiver-detect sequencer: request edge, detect timing counter and detect FSM
`timescale 1ns/1ps
`include "pipe_phy_consts.svh"

module rx_detect_seq (
   input  logic                       PCLK,
   input  logic                       RESET_n,
   input  pipe_phy_pkg::power_state_e power_down,
   input  logic                       tx_detect_rx,
   input  logic [`PHY_LANES-1:0]      tx_elec_idle,
   input  logic                       det_complete,
   output logic                       det_start,
   output logic                       pcie_ct,
   output logic                       seq_wait
);

   pipe_phy_pkg::det_state_e state;
   logic                     det_req;
   logic                     req_q;
   logic                     req_d;
   logic                     req_dd;
   logic                     req_rise;
   logic [`DET_CNT_W-1:0]    det_cnt;
   logic                     en_done;

   // Detect only legal in P1 with every transmitter idle
   assign det_req = tx_detect_rx && (power_down == pipe_phy_pkg::P1) && (&tx_elec_idle);

   // Edge taken on the second stage, keeps the PIPE input off the FSM path
   assign req_rise = req_d & ~req_dd;

   // Lanes may only act on done while the sequencer is waiting
   assign seq_wait = (state == pipe_phy_pkg::DET_WAIT_DONE);

   // ========================================
   // Request pipeline
   // ========================================
   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         req_q  <= 1'b0;
         req_d  <= 1'b0;
         req_dd <= 1'b0;
      end else begin
         req_q  <= det_req;
         req_d  <= req_q;
         req_dd <= req_d;
      end
   end

   // Registered terminal count of the enable period
   // adds one clock after det_cnt reaches the limit
   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         en_done <= 1'b0;
      end else begin
         en_done <= (state == pipe_phy_pkg::DET_EN) &&
                    (det_cnt == `DET_CNT_W'(`DET_EN_CYCLES));
      end
   end

   // ========================================
   // Detect FSM
   // ========================================
   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         state     <= pipe_phy_pkg::DET_IDLE;
         det_start <= 1'b0;
         pcie_ct   <= 1'b0;
         det_cnt   <= '0;
      end else begin
         // Start is a single clock
         det_start <= 1'b0;
         case (state)
            pipe_phy_pkg::DET_IDLE: begin
               pcie_ct <= 1'b0;
               det_cnt <= '0;
               if (req_rise) begin
                  state     <= pipe_phy_pkg::DET_EN;
                  det_start <= 1'b1;
               end
            end
            pipe_phy_pkg::DET_EN: begin
               // Lanes raise det_en one clock after start, count from there
               if (!det_start)
                  det_cnt <= det_cnt + 1'b1;
               if (en_done) begin
                  state   <= pipe_phy_pkg::DET_CT;
                  pcie_ct <= 1'b1;
                  det_cnt <= '0;
               end
            end
            pipe_phy_pkg::DET_CT: begin
               det_cnt <= det_cnt + 1'b1;
               // Pulse spans DET_CT_CYCLES plus the entry clock
               if (det_cnt == `DET_CNT_W'(`DET_CT_CYCLES)) begin
                  state   <= pipe_phy_pkg::DET_WAIT_DONE;
                  pcie_ct <= 1'b0;
                  det_cnt <= '0;
               end
            end
            pipe_phy_pkg::DET_WAIT_DONE: begin
               // Variable latency, ends when all lanes are done
               if (det_complete)
                  state <= pipe_phy_pkg::DET_IDLE;
            end
            default: begin
               state   <= pipe_phy_pkg::DET_IDLE;
               pcie_ct <= 1'b0;
            end
         endcase
      end
   end

endmodule

//--- lane/lane_ctrl.sv
// Per-lane controller: done synchronizer, detect enable, presence latch, RxValid qualifier
`timescale 1ns/1ps
`include "pipe_phy_consts.svh"

module lane_ctrl (
   input  logic                    PCLK,
   input  logic                    RESET_n,
   input  logic                    det_start,
   input  logic                    seq_wait,
   input  logic                    pcie_done,
   input  logic                    pcie_con,
   input  logic                    pcs_rx_valid,
   input  logic                    rx_elec_idle,
   input  logic                    rx_lol,
   input  logic [`RX_STATUS_W-1:0] rx_status,
   input  logic                    core_rstn,
   input  logic                    phy_l0,
   output logic                    det_en,
   output logic                    done_sync,
   output logic                    lane_present,
   output logic                    rx_valid
);

   logic                 done_s0;
   logic                 done_s1;
   logic                 done_q;
   logic                 done_edge;
   logic                 rx_fault;
   logic                 rx_clean;
   logic                 cnt_hit;
   logic [`RX_CNT_W-1:0] rx_cnt;

   // Done leaves the synchronizer here for the monitor
   assign done_sync = done_s1;

   // ========================================
   // Done synchronizer and edge
   // ========================================
   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         done_s0   <= 1'b0;
         done_s1   <= 1'b0;
         done_q    <= 1'b0;
         done_edge <= 1'b0;
      end else begin
         // PCS status is asynchronous to PCLK
         done_s0   <= pcie_done;
         done_s1   <= done_s0;
         done_q    <= done_s1;
         // Registered rise, one clock wide
         done_edge <= done_s1 & ~done_q;
      end
   end

   // Detect enable and presence
   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         det_en       <= 1'b0;
         lane_present <= 1'b0;
      end else if (det_start) begin
         // New detect forgets the old result
         det_en       <= 1'b1;
         lane_present <= 1'b0;
      end else if (done_edge && seq_wait) begin
         det_en       <= 1'b0;
         lane_present <= pcie_con;
      end
   end

   // ========================================
   // RxValid qualification
   // ========================================
   assign rx_fault = rx_elec_idle | rx_lol;
   assign rx_clean = core_rstn & pcs_rx_valid & ~rx_fault & (rx_status == '0);
   assign cnt_hit  = (rx_cnt == `RX_CNT_W'(`RX_STABLE_CYCLES));

   // Stability counter, restarts on any unclean cycle
   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n)
         rx_cnt <= '0;
      else if (!rx_clean)
         rx_cnt <= '0;
      else if (!cnt_hit)
         rx_cnt <= rx_cnt + 1'b1;
   end

   // L0 pass-through wins, then count reached, then fault clear
   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n)
         rx_valid <= 1'b0;
      else if (phy_l0 && core_rstn && pcs_rx_valid && !rx_fault)
         rx_valid <= pcs_rx_valid;
      else if (rx_clean && cnt_hit)
         rx_valid <= 1'b1;
      else if (!core_rstn || !pcs_rx_valid || rx_fault)
         rx_valid <= 1'b0;
   end

endmodule

//--- design/phy_state_monitor.sv
// PHY state monitor: PLL lock and reset synchronizers, all-done edge, PhyStatus
`timescale 1ns/1ps
`include "pipe_phy_consts.svh"

module phy_state_monitor (
   input  logic                       PCLK,
   input  logic                       RESET_n,
   input  logic                       pll_lol,
   input  logic                       rsl_rx_rdy,
   input  pipe_phy_pkg::power_state_e power_down,
   input  logic [`PHY_LANES-1:0]      done_sync,
   output logic                       det_complete,
   output logic                       core_rstn,
   output logic                       phy_status
);

   logic                       plol_s0;
   logic                       plol_s1;
   logic                       rdy_s0;
   logic                       done_all;
   logic                       done_all_q;
   pipe_phy_pkg::power_state_e pd_q;

   // PIPE power transitions that report PhyStatus
   function automatic logic legal_change(input pipe_phy_pkg::power_state_e from_ps,
                                         input pipe_phy_pkg::power_state_e to_ps);
      case (from_ps)
         pipe_phy_pkg::P0:  return (to_ps != pipe_phy_pkg::P0);
         pipe_phy_pkg::P0S: return (to_ps == pipe_phy_pkg::P0);
         pipe_phy_pkg::P1:  return (to_ps == pipe_phy_pkg::P0);
         pipe_phy_pkg::P2:  return (to_ps == pipe_phy_pkg::P0) || (to_ps == pipe_phy_pkg::P1);
         default:           return 1'b0;
      endcase
   endfunction

   // All lanes done, one clock after the last rise
   assign det_complete = done_all & ~done_all_q;

   // ========================================
   // Synchronizers and status
   // ========================================
   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         plol_s0    <= 1'b1;
         plol_s1    <= 1'b1;
         rdy_s0     <= 1'b0;
         core_rstn  <= 1'b0;
         done_all   <= 1'b0;
         done_all_q <= 1'b0;
         pd_q       <= pipe_phy_pkg::P0;
         phy_status <= 1'b1;
      end else begin
         plol_s0    <= pll_lol;
         plol_s1    <= plol_s0;
         // Core reset follows the PCS receive-ready
         rdy_s0     <= rsl_rx_rdy;
         core_rstn  <= rdy_s0;
         done_all   <= &done_sync;
         done_all_q <= done_all;
         pd_q       <= power_down;
         // PhyStatus held high until the PLL locks
         if (!plol_s1)
            phy_status <= legal_change(pd_q, power_down) || det_complete;
      end
   end

endmodule

//--- design/pipe_phy_ctrl.sv
// Top level: detect sequencer, per-lane controllers and PHY state monitor
`timescale 1ns/1ps
`include "pipe_phy_consts.svh"

module pipe_phy_ctrl (
   input  logic                                PCLK,
   input  logic                                RESET_n,
   // PIPE MAC side
   input  pipe_phy_pkg::power_state_e          power_down,
   input  logic                                tx_detect_rx,
   input  logic [`PHY_LANES-1:0]               tx_elec_idle,
   input  logic                                phy_l0,
   // PCS status
   input  logic [`PHY_LANES-1:0]               pcie_done,
   input  logic [`PHY_LANES-1:0]               pcie_con,
   input  logic [`PHY_LANES-1:0]               pcs_rx_valid,
   input  logic [`PHY_LANES-1:0]               rx_elec_idle,
   input  logic [`PHY_LANES-1:0]               rx_lol,
   input  logic [`PHY_LANES*`RX_STATUS_W-1:0]  rx_status,
   input  logic                                pll_lol,
   input  logic                                rsl_rx_rdy,
   // PCS controls and PIPE status
   output logic [`PHY_LANES-1:0]               det_en,
   output logic                                pcie_ct,
   output logic                                phy_status,
   output logic [`PHY_LANES-1:0]               lane_present,
   output logic [`PHY_LANES-1:0]               rx_valid,
   output logic                                pcie_ip_rstn
);

   logic                  det_start;
   logic                  seq_wait;
   logic                  det_complete;
   logic                  core_rstn;
   logic [`PHY_LANES-1:0] done_sync;

   assign pcie_ip_rstn = core_rstn;

   // ========================================
   // Detect sequencer
   // ========================================
   rx_detect_seq u_seq (
      .PCLK         (PCLK),
      .RESET_n      (RESET_n),
      .power_down   (power_down),
      .tx_detect_rx (tx_detect_rx),
      .tx_elec_idle (tx_elec_idle),
      .det_complete (det_complete),
      .det_start    (det_start),
      .pcie_ct      (pcie_ct),
      .seq_wait     (seq_wait)
   );

   // One controller per lane
   for (genvar g = 0; g < `PHY_LANES; g++) begin : g_lane
      lane_ctrl u_lane (
         .PCLK         (PCLK),
         .RESET_n      (RESET_n),
         .det_start    (det_start),
         .seq_wait     (seq_wait),
         .pcie_done    (pcie_done[g]),
         .pcie_con     (pcie_con[g]),
         .pcs_rx_valid (pcs_rx_valid[g]),
         .rx_elec_idle (rx_elec_idle[g]),
         .rx_lol       (rx_lol[g]),
         .rx_status    (rx_status[g*`RX_STATUS_W +: `RX_STATUS_W]),
         .core_rstn    (core_rstn),
         .phy_l0       (phy_l0),
         .det_en       (det_en[g]),
         .done_sync    (done_sync[g]),
         .lane_present (lane_present[g]),
         .rx_valid     (rx_valid[g])
      );
   end

   // Drains done flags, owns PhyStatus and core reset
   phy_state_monitor u_mon (
      .PCLK         (PCLK),
      .RESET_n      (RESET_n),
      .pll_lol      (pll_lol),
      .rsl_rx_rdy   (rsl_rx_rdy),
      .power_down   (power_down),
      .done_sync    (done_sync),
      .det_complete (det_complete),
      .core_rstn    (core_rstn),
      .phy_status   (phy_status)
   );

endmodule

//--- tb/pipe_phy_ctrl_asserts.sv
// Bound assertions: charge timing under detect enable, RxValid drop on core reset and faults
`timescale 1ns/1ps
`include "pipe_phy_consts.svh"

module pipe_phy_ctrl_asserts (
   input logic                  PCLK,
   input logic                  RESET_n,
   input logic [`PHY_LANES-1:0] det_en,
   input logic                  pcie_ct,
   input logic                  pcie_ip_rstn,
   input logic [`PHY_LANES-1:0] rx_valid,
   input logic [`PHY_LANES-1:0] rx_elec_idle,
   input logic [`PHY_LANES-1:0] rx_lol,
   input logic                  phy_l0
);

   // Charge current only flows while every lane is in detect
   ct_under_det_en: assert property (@(posedge PCLK) disable iff (!RESET_n)
      pcie_ct |-> (&det_en))
      else $error("pcie_ct high without det_en on all lanes");

   // Core reset empties every lane one clock later
   rstn_clears_valid: assert property (@(posedge PCLK) disable iff (!RESET_n)
      !pcie_ip_rstn |=> (rx_valid == '0))
      else $error("rx_valid still set one clock after core reset");

   // Outside L0 a lane fault drops that lane only
   for (genvar g = 0; g < `PHY_LANES; g++) begin : g_fault
      fault_clears_valid: assert property (@(posedge PCLK) disable iff (!RESET_n)
         ((rx_elec_idle[g] || rx_lol[g]) && !phy_l0) |=> !rx_valid[g])
         else $error("rx_valid on lane %0d still set after a fault", g);
   end

endmodule

bind pipe_phy_ctrl pipe_phy_ctrl_asserts u_asserts (
   .PCLK         (PCLK),
   .RESET_n      (RESET_n),
   .det_en       (det_en),
   .pcie_ct      (pcie_ct),
   .pcie_ip_rstn (pcie_ip_rstn),
   .rx_valid     (rx_valid),
   .rx_elec_idle (rx_elec_idle),
   .rx_lol       (rx_lol),
   .phy_l0       (phy_l0)
);

//--- tb/pipe_phy_ctrl_tb.sv
// Testbench top with clock, reset, PCS done model, detect table loop and RxValid checks
`timescale 1ns/1ps
`include "pipe_phy_consts.svh"

module pipe_phy_ctrl_tb;

   // One detect scenario per row
   // done_order holds 2-bit lane numbers with the first responder in the low bits
   typedef struct packed {
      pipe_phy_pkg::power_state_e ps;
      logic [`PHY_LANES-1:0]      con_mask;
      logic [2*`PHY_LANES-1:0]    done_order;
      logic [`PHY_LANES-1:0]      exp_present;
      int                         exp_pwr;
      int                         exp_pulses;
   } row_t;

   localparam int ROWS = 9;

   logic                               PCLK;
   logic                               RESET_n;
   pipe_phy_pkg::power_state_e         power_down;
   logic                               tx_detect_rx;
   logic [`PHY_LANES-1:0]              tx_elec_idle;
   logic                               phy_l0;
   logic [`PHY_LANES-1:0]              pcie_done;
   logic [`PHY_LANES-1:0]              pcie_con;
   logic [`PHY_LANES-1:0]              pcs_rx_valid;
   logic [`PHY_LANES-1:0]              rx_elec_idle;
   logic [`PHY_LANES-1:0]              rx_lol;
   logic [`PHY_LANES*`RX_STATUS_W-1:0] rx_status;
   logic                               pll_lol;
   logic                               rsl_rx_rdy;
   logic [`PHY_LANES-1:0]              det_en;
   logic                               pcie_ct;
   logic                               phy_status;
   logic [`PHY_LANES-1:0]              lane_present;
   logic [`PHY_LANES-1:0]              rx_valid;
   logic                               pcie_ip_rstn;

   row_t   rows [ROWS];
   integer seed;
   int     err_cnt;
   int     to_cnt;
   int     pulse_cnt;
   int     ticks;

   pipe_phy_ctrl dut (.*);

   always #50 PCLK = ~PCLK;

   // ========================================
   // Helpers
   // ========================================

   // Advance one clock to the drive point and tally PhyStatus high cycles
   task automatic tick();
      @(posedge PCLK);
      #5;
      if (phy_status)
         pulse_cnt++;
   endtask

   task automatic report_mismatch(input string name, input int exp_v, input int got_v);
      err_cnt++;
      $display("error at %0t ns: %s expected %0h, got %0h", $time, name, exp_v, got_v);
   endtask

   task automatic summarize_and_finish();
      $display("Summary: %0d value errors, %0d timeouts", err_cnt, to_cnt);
      if (err_cnt == 0 && to_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   task automatic timed_out(input string what);
      to_cnt++;
      $display("timeout: %s did not happen in time", what);
   endtask

   // Power path P0 P1 P0S P0 P2 P1 P0 P1 P2 P1
   // P1 to P0S and P1 to P2 report no PhyStatus
   // Each P1 row adds the detect pulse
   task automatic load_table();
      rows[0] = '{pipe_phy_pkg::P1,  4'b1111, 8'b11_10_01_00, 4'b1111, 1, 2};
      rows[1] = '{pipe_phy_pkg::P0S, 4'b1111, 8'b11_10_01_00, 4'b1111, 0, 0};
      rows[2] = '{pipe_phy_pkg::P0,  4'b0000, 8'b11_10_01_00, 4'b1111, 1, 1};
      rows[3] = '{pipe_phy_pkg::P2,  4'b0000, 8'b11_10_01_00, 4'b1111, 1, 1};
      rows[4] = '{pipe_phy_pkg::P1,  4'b0101, 8'b10_00_01_11, 4'b0101, 1, 2};
      rows[5] = '{pipe_phy_pkg::P0,  4'b0000, 8'b10_00_01_11, 4'b0101, 1, 1};
      rows[6] = '{pipe_phy_pkg::P1,  4'b1010, 8'b01_11_00_10, 4'b1010, 1, 2};
      rows[7] = '{pipe_phy_pkg::P2,  4'b0000, 8'b01_11_00_10, 4'b1010, 0, 0};
      rows[8] = '{pipe_phy_pkg::P1,  4'b0000, 8'b00_10_11_01, 4'b0000, 1, 2};
   endtask

   // ========================================
   // Detect scenario
   // ========================================
   task automatic run_row(input int r);
      int   lane;
      int   delay;
      logic det_run;
      det_run   = (rows[r].ps == pipe_phy_pkg::P1);
      pcie_con  = rows[r].con_mask;
      pulse_cnt = 0;
      power_down = rows[r].ps;
      // PhyStatus answers a legal change on the next clock
      tick();
      if (phy_status !== rows[r].exp_pwr[0])
         report_mismatch("phy_status after power change", rows[r].exp_pwr, int'(phy_status));
      repeat (3) tick();
      tx_detect_rx = 1'b1;
      // Request sampled on this edge
      tick();
      if (det_run) begin
         ticks = 0;
         while (det_en !== '1) begin
            tick();
            ticks++;
            if (ticks > 10) begin
               timed_out("det_en rise after the detect request");
               break;
            end
         end
         if (ticks != 3)
            report_mismatch("det_en rise delay", 3, ticks);
         tx_detect_rx = 1'b0;
         ticks = 0;
         while (pcie_ct !== 1'b1) begin
            tick();
            ticks++;
            if (ticks > 2 * `DET_EN_CYCLES) begin
               timed_out("pcie_ct rise");
               break;
            end
         end
         if (ticks != `DET_EN_CYCLES + 2)
            report_mismatch("pcie_ct rise delay", `DET_EN_CYCLES + 2, ticks);
         ticks = 0;
         while (pcie_ct === 1'b1) begin
            tick();
            ticks++;
            if (ticks > 4 * `DET_CT_CYCLES) begin
               timed_out("pcie_ct fall");
               break;
            end
         end
         if (ticks != `DET_CT_CYCLES + 1)
            report_mismatch("pcie_ct width", `DET_CT_CYCLES + 1, ticks);
         // PCS model answers lanes in table order after a random gap
         for (int i = 0; i < `PHY_LANES; i++) begin
            lane  = int'(rows[r].done_order[2*i +: 2]);
            delay = 1 + int'($unsigned($random(seed)) % 8);
            repeat (delay) tick();
            pcie_done[lane] = 1'b1;
            ticks = 0;
            while (det_en[lane] !== 1'b0) begin
               tick();
               ticks++;
               if (ticks > 10) begin
                  timed_out("det_en fall after the lane done");
                  break;
               end
            end
         end
         // Room for the completion pulse and anything spurious after it
         repeat (6) tick();
      end else begin
         for (int i = 0; i < 8; i++) begin
            tick();
            if (det_en !== '0)
               report_mismatch("det_en outside P1", 0, int'(det_en));
         end
         tx_detect_rx = 1'b0;
      end
      if (lane_present !== rows[r].exp_present)
         report_mismatch("lane_present", int'(rows[r].exp_present), int'(lane_present));
      if (pulse_cnt != rows[r].exp_pulses)
         report_mismatch("phy_status pulse count", rows[r].exp_pulses, pulse_cnt);
      pcie_done = '0;
      repeat (4) tick();
   endtask

   // ========================================
   // RxValid qualification
   // ========================================
   task automatic check_rx_path();
      pcs_rx_valid = '1;
      rx_elec_idle = '0;
      rx_lol       = '0;
      // Nothing may qualify while the core is held in reset
      for (int i = 0; i < `RX_STABLE_CYCLES + 20; i++) begin
         tick();
         if (rx_valid !== '0)
            report_mismatch("rx_valid in core reset", 0, int'(rx_valid));
      end
      rsl_rx_rdy = 1'b1;
      ticks = 0;
      while (pcie_ip_rstn !== 1'b1) begin
         tick();
         ticks++;
         if (ticks > 10) begin
            timed_out("pcie_ip_rstn rise");
            break;
         end
      end
      if (ticks != 2)
         report_mismatch("pcie_ip_rstn delay", 2, ticks);
      // rx_valid registers one clock after the counter reaches the limit
      ticks = 0;
      while (rx_valid !== '1) begin
         tick();
         ticks++;
         if (ticks > 4 * `RX_STABLE_CYCLES) begin
            timed_out("rx_valid qualification");
            break;
         end
      end
      if (ticks != `RX_STABLE_CYCLES + 1)
         report_mismatch("rx_valid qualify delay", `RX_STABLE_CYCLES + 1, ticks);
      rx_elec_idle[0] = 1'b1;
      tick();
      if (rx_valid !== 4'b1110)
         report_mismatch("rx_valid after elec idle", 'hE, int'(rx_valid));
      // Lane 0 restarts its count while lane 1 loses lock
      rx_elec_idle[0] = 1'b0;
      rx_lol[1]       = 1'b1;
      tick();
      if (rx_valid !== 4'b1100)
         report_mismatch("rx_valid after loss of lock", 'hC, int'(rx_valid));
      // L0 bypasses the count
      phy_l0    = 1'b1;
      rx_lol[1] = 1'b0;
      tick();
      if (rx_valid !== '1)
         report_mismatch("rx_valid in L0", 'hF, int'(rx_valid));
      pcs_rx_valid[2] = 1'b0;
      tick();
      if (rx_valid !== 4'b1011)
         report_mismatch("rx_valid follow low", 'hB, int'(rx_valid));
      pcs_rx_valid[2] = 1'b1;
      tick();
      if (rx_valid !== '1)
         report_mismatch("rx_valid follow high", 'hF, int'(rx_valid));
      phy_l0     = 1'b0;
      rsl_rx_rdy = 1'b0;
      ticks = 0;
      while (pcie_ip_rstn !== 1'b0) begin
         tick();
         ticks++;
         if (ticks > 10) begin
            timed_out("pcie_ip_rstn fall");
            break;
         end
      end
      tick();
      if (rx_valid !== '0)
         report_mismatch("rx_valid after core reset", 0, int'(rx_valid));
   endtask

   // ========================================
   // Main sequence
   // ========================================
   initial begin
      seed         = 32'h8f844330;
      err_cnt      = 0;
      to_cnt       = 0;
      pulse_cnt    = 0;
      ticks        = 0;
      PCLK         = 1'b0;
      RESET_n      = 1'b0;
      power_down   = pipe_phy_pkg::P0;
      tx_detect_rx = 1'b0;
      tx_elec_idle = '1;
      phy_l0       = 1'b0;
      pcie_done    = '0;
      pcie_con     = '0;
      pcs_rx_valid = '0;
      rx_elec_idle = '1;
      rx_lol       = '0;
      rx_status    = '0;
      pll_lol      = 1'b1;
      rsl_rx_rdy   = 1'b0;
      load_table();
      repeat (16) @(posedge PCLK);
      #5;
      if (det_en !== '0)
         report_mismatch("det_en in reset", 0, int'(det_en));
      if (pcie_ct !== 1'b0)
         report_mismatch("pcie_ct in reset", 0, int'(pcie_ct));
      if (rx_valid !== '0)
         report_mismatch("rx_valid in reset", 0, int'(rx_valid));
      if (lane_present !== '0)
         report_mismatch("lane_present in reset", 0, int'(lane_present));
      if (pcie_ip_rstn !== 1'b0)
         report_mismatch("pcie_ip_rstn in reset", 0, int'(pcie_ip_rstn));
      if (phy_status !== 1'b1)
         report_mismatch("phy_status in reset", 1, int'(phy_status));
      RESET_n = 1'b1;
      repeat (4) tick();
      if (phy_status !== 1'b1)
         report_mismatch("phy_status before PLL lock", 1, int'(phy_status));
      pll_lol = 1'b0;
      ticks = 0;
      while (phy_status !== 1'b0) begin
         tick();
         ticks++;
         if (ticks > 10) begin
            timed_out("phy_status fall after PLL lock");
            break;
         end
      end
      repeat (4) tick();
      if (phy_status !== 1'b0)
         report_mismatch("phy_status after PLL lock", 0, int'(phy_status));
      for (int r = 0; r < ROWS; r++)
         run_row(r);
      check_rx_path();
      summarize_and_finish();
   end

endmodule

//--- src.f
+incdir+common
common/pipe_phy_pkg.sv
rx_detect/rx_detect_seq.sv
lane/lane_ctrl.sv
design/phy_state_monitor.sv
design/pipe_phy_ctrl.sv
tb/pipe_phy_ctrl_asserts.sv
tb/pipe_phy_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the PIPE PHY control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f src.f --top-module pipe_phy_ctrl_tb -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q -F '*** PASSED ***' sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
